//--- axi_lite_master_top.f
logic/axi_lite_pkg.sv
logic/host_pkg.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/bridge_cfg_regs.sv
logic/axi_lite_master_top.sv
dv/axi_lite_slave_model.sv
dv/tb_axi_lite_master.sv

//--- dv/axi_lite_slave_model.sv
`timescale 1ns/1ps

module axi_lite_slave_model (
    input  logic                  clk,
    input  logic                  rst,
    input  axi_lite_pkg::axi_aw_t aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axi_lite_pkg::axi_w_t  w,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_lite_pkg::axi_b_t  b,
    output logic                  bvalid,
    input  logic                  bready,
    input  axi_lite_pkg::axi_ar_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output axi_lite_pkg::axi_r_t  r,
    output logic                  rvalid,
    input  logic                  rready
);
    import axi_lite_pkg::*;

    logic [data_w-1:0] mem [logic [addr_w-3:0]];
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;
    logic [addr_w-1:0] rd_addr;
    logic              aw_got;
    logic              w_got;
    logic              ar_got;
    logic [1:0]        aw_dly;
    logic [1:0]        w_dly;
    logic [1:0]        ar_dly;
    logic [1:0]        r_dly;
    integer            seed = 32'h13a7;

    function automatic logic [1:0] next_delay();
        logic [31:0] v;
        v = $random(seed);
        return v[1:0];
    endfunction

    // bit 11 wins over bit 10
    function automatic axi_resp_e resp_for(logic [addr_w-1:0] addr);
        if (addr[11]) return slverr;
        if (addr[10]) return decerr;
        return okay;
    endfunction

    function automatic logic [data_w-1:0] read_word(logic [addr_w-1:0] addr);
        if (resp_for(addr) != okay) return '0;
        if (mem.exists(addr[addr_w-1:2])) return mem[addr[addr_w-1:2]];
        // unwritten words read back a pattern of their address
        return addr ^ 32'h5ca1_ab1e;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            b       <= '0;
            r       <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_dly  <= '0;
            w_dly   <= '0;
            ar_dly  <= '0;
            r_dly   <= '0;
        end else begin
            // ready lines pulse for one cycle after the drawn delay
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            if (awvalid && !awready && !aw_got) begin
                if (aw_dly == 2'd0) awready <= 1'b1;
                else aw_dly <= aw_dly - 2'd1;
            end
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_addr <= aw.addr;
                aw_dly  <= next_delay();
            end
            if (wvalid && !wready && !w_got) begin
                if (w_dly == 2'd0) wready <= 1'b1;
                else w_dly <= w_dly - 2'd1;
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= w.data;
                w_dly   <= next_delay();
            end
            if (aw_got && w_got && !bvalid) begin
                bvalid <= 1'b1;
                b.resp <= resp_for(wr_addr);
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                if (resp_for(wr_addr) == okay) mem[wr_addr[addr_w-1:2]] = wr_data;
            end
            // addresses with bit 12 set hang forever
            if (arvalid && !arready && !ar_got && !ar.addr[12]) begin
                if (ar_dly == 2'd0) arready <= 1'b1;
                else ar_dly <= ar_dly - 2'd1;
            end
            if (arvalid && arready) begin
                ar_got  <= 1'b1;
                rd_addr <= ar.addr;
                ar_dly  <= next_delay();
                r_dly   <= next_delay();
            end
            if (ar_got && !rvalid) begin
                if (r_dly == 2'd0) begin
                    rvalid <= 1'b1;
                    r.data <= read_word(rd_addr);
                    r.resp <= resp_for(rd_addr);
                end else begin
                    r_dly <= r_dly - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                ar_got <= 1'b0;
            end
        end
    end

endmodule

//--- dv/tb_axi_lite_master.sv
`timescale 1ns/1ps

module tb_axi_lite_master;
    import axi_lite_pkg::*;
    import host_pkg::*;

    // about 300 transactions of at most about 40 cycles
    localparam int cycle_limit = 20000;

    logic              clk;
    logic              rst;
    logic              wr_req;
    logic              rd_req;
    host_req_t         req;
    logic              wr_done;
    host_rsp_t         wr_rsp;
    logic              rd_done;
    host_rsp_t         rd_rsp;
    logic              wr_busy;
    logic              rd_busy;
    logic              cfg_we;
    logic [tmo_w-1:0]  cfg_limit;
    logic [tmo_w-1:0]  err_count;
    logic [tmo_w-1:0]  tmo_count;
    axi_aw_t           aw;
    logic              awvalid;
    logic              awready;
    axi_w_t            w;
    logic              wvalid;
    logic              wready;
    axi_b_t            b;
    logic              bvalid;
    logic              bready;
    axi_ar_t           ar;
    logic              arvalid;
    logic              arready;
    axi_r_t            r;
    logic              rvalid;
    logic              rready;

    logic [data_w-1:0] shadow [logic [addr_w-3:0]];
    host_rsp_t         wr_exp_q [$];
    host_rsp_t         rd_exp_q [$];
    integer            seed;
    int                cycles = 0;
    int                err_exp;
    int                tmo_exp;
    int                cur_limit;
    int                rd_issue_cycle;
    int                rd_exp_lat;
    logic [addr_w-1:0] wr_pend_addr;
    logic [addr_w-1:0] rd_pend_addr;

    axi_lite_master_top u_dut (.*);

    axi_lite_slave_model u_slave (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rsp(string name, host_rsp_t got, host_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %s/%h, expected %s/%h", $time,
                name, got.status.name(), got.data, exp.status.name(), exp.data));
        end
    endtask

    task automatic check_count(string name, logic [tmo_w-1:0] got, logic [tmo_w-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %0d, expected %0d", $time,
                name, got, exp));
        end
    endtask

    task automatic check_latency(string name, int got, int exp);
        if (got != exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %0d cycles, expected %0d", $time,
                name, got, exp));
        end
    endtask

    // reads hang on bit 12, then slverr on bit 11 and decerr on bit 10
    function automatic host_rsp_t expected_rsp(logic is_wr, logic [addr_w-1:0] addr);
        host_rsp_t rsp;
        rsp.data = '0;
        if (!is_wr && addr[12]) begin
            rsp.status = st_timeout;
        end else if (addr[11]) begin
            rsp.status = st_slverr;
        end else if (addr[10]) begin
            rsp.status = st_decerr;
        end else begin
            rsp.status = st_okay;
            if (!is_wr) begin
                if (shadow.exists(addr[addr_w-1:2])) rsp.data = shadow[addr[addr_w-1:2]];
                else rsp.data = addr ^ 32'h5ca1_ab1e;
            end
        end
        return rsp;
    endfunction

    task automatic send_req(logic is_wr, logic [addr_w-1:0] addr, logic [data_w-1:0] data);
        host_rsp_t exp;
        // the other engine must not hold the same word
        do begin
            @(posedge clk);
        end while (is_wr ? (wr_busy || (rd_busy && rd_pend_addr == addr))
                         : (rd_busy || (wr_busy && wr_pend_addr == addr)));
        exp = expected_rsp(is_wr, addr);
        if (exp.status == st_slverr || exp.status == st_decerr) err_exp++;
        if (exp.status == st_timeout) tmo_exp++;
        req <= {addr, data};
        if (is_wr) begin
            wr_req <= 1'b1;
            wr_pend_addr = addr;
            wr_exp_q.push_back(exp);
            if (exp.status == st_okay) shadow[addr[addr_w-1:2]] = data;
        end else begin
            rd_req <= 1'b1;
            rd_pend_addr = addr;
            rd_issue_cycle = cycles;
            rd_exp_lat = cur_limit + 1;
            rd_exp_q.push_back(exp);
        end
        @(posedge clk);
        wr_req <= 1'b0;
        rd_req <= 1'b0;
    endtask

    task automatic write_limit(logic [tmo_w-1:0] value);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_limit <= value;
        @(posedge clk);
        cfg_we <= 1'b0;
        if (value != '0) cur_limit = int'(value);
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (wr_busy || rd_busy);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("timeout: run still going after %0d cycles", cycle_limit));
        end
    end

    always @(posedge clk) begin
        host_rsp_t exp;
        if (!rst && wr_done) begin
            if (wr_exp_q.size() == 0) abort_run("write completion with no write outstanding");
            else check_rsp("wr_rsp", wr_rsp, wr_exp_q.pop_front());
        end
        if (!rst && rd_done) begin
            if (rd_exp_q.size() == 0) begin
                abort_run("read completion with no read outstanding");
            end else begin
                exp = rd_exp_q.pop_front();
                check_rsp("rd_rsp", rd_rsp, exp);
                // request cycle to done cycle
                if (exp.status == st_timeout) begin
                    check_latency("rd_done", cycles - rd_issue_cycle - 1, rd_exp_lat);
                end
            end
        end
    end

    initial begin
        logic [31:0]       rnd;
        logic [data_w-1:0] data;
        logic [addr_w-1:0] addr;
        logic              is_wr;
        rst       <= 1'b1;
        wr_req    <= 1'b0;
        rd_req    <= 1'b0;
        req       <= '0;
        cfg_we    <= 1'b0;
        cfg_limit <= '0;
        seed         = 32'h13a7;
        err_exp      = 0;
        tmo_exp      = 0;
        cur_limit    = tmo_default;
        wr_pend_addr = '0;
        rd_pend_addr = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        send_req(1'b1, 32'h0000_0100, 32'ha5a5_1234);
        send_req(1'b0, 32'h0000_0100, '0);

        send_req(1'b1, 32'h0000_0800, 32'h1111_2222);
        send_req(1'b0, 32'h0000_0804, '0);
        send_req(1'b1, 32'h0000_0400, 32'h3333_4444);
        send_req(1'b0, 32'h0000_0408, '0);
        wait_idle();
        check_count("err_count", err_count, tmo_w'(err_exp));

        // hung read at the reset limit
        send_req(1'b0, 32'h0000_1000, '0);
        wait_idle();
        check_count("tmo_count", tmo_count, tmo_w'(tmo_exp));

        write_limit(8'd20);
        send_req(1'b0, 32'h0000_1004, '0);
        write_limit(8'd0);
        send_req(1'b0, 32'h0000_1008, '0);
        wait_idle();
        check_count("tmo_count", tmo_count, tmo_w'(tmo_exp));

        repeat (250) begin
            rnd  = $random(seed);
            data = $random(seed);
            is_wr = rnd[0];
            addr  = {20'h0, 6'h0, rnd[4:1], 2'b00};
            // each error kind one time in eight, and some reads hang
            if (rnd[7:5] == 3'd0) addr[11] = 1'b1;
            else if (rnd[7:5] == 3'd1) addr[10] = 1'b1;
            else if (rnd[12:8] == 5'd0 && !is_wr) addr[12] = 1'b1;
            send_req(is_wr, addr, data);
        end
        wait_idle();
        check_count("err_count", err_count, tmo_w'(err_exp));
        check_count("tmo_count", tmo_count, tmo_w'(tmo_exp));

        if (wr_exp_q.size() == 0 && rd_exp_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run($sformatf("%0d writes and %0d reads never completed",
                wr_exp_q.size(), rd_exp_q.size()));
        end
    end

endmodule

//--- logic/axi_lite_master_top.sv
`timescale 1ns/1ps

module axi_lite_master_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_req,
    input  logic                       rd_req,
    input  host_pkg::host_req_t        req,
    output logic                       wr_done,
    output host_pkg::host_rsp_t        wr_rsp,
    output logic                       rd_done,
    output host_pkg::host_rsp_t        rd_rsp,
    output logic                       wr_busy,
    output logic                       rd_busy,
    input  logic                       cfg_we,
    input  logic [host_pkg::tmo_w-1:0] cfg_limit,
    output logic [host_pkg::tmo_w-1:0] err_count,
    output logic [host_pkg::tmo_w-1:0] tmo_count,
    output axi_lite_pkg::axi_aw_t      aw,
    output logic                       awvalid,
    input  logic                       awready,
    output axi_lite_pkg::axi_w_t       w,
    output logic                       wvalid,
    input  logic                       wready,
    input  axi_lite_pkg::axi_b_t       b,
    input  logic                       bvalid,
    output logic                       bready,
    output axi_lite_pkg::axi_ar_t      ar,
    output logic                       arvalid,
    input  logic                       arready,
    input  axi_lite_pkg::axi_r_t       r,
    input  logic                       rvalid,
    output logic                       rready
);
    import host_pkg::*;

    logic [tmo_w-1:0] timeout_limit;

    axi_write_engine u_wr (
        .clk     (clk),
        .rst     (rst),
        .wr_req  (wr_req),
        .req     (req),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_done (wr_done),
        .wr_rsp  (wr_rsp),
        .busy    (wr_busy)
    );

    axi_read_engine u_rd (
        .clk           (clk),
        .rst           (rst),
        .rd_req        (rd_req),
        .req           (req),
        .timeout_limit (timeout_limit),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .rd_done       (rd_done),
        .rd_rsp        (rd_rsp),
        .busy          (rd_busy)
    );

    bridge_cfg_regs u_cfg (
        .clk           (clk),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_limit     (cfg_limit),
        .wr_done       (wr_done),
        .wr_rsp        (wr_rsp),
        .rd_done       (rd_done),
        .rd_rsp        (rd_rsp),
        .timeout_limit (timeout_limit),
        .err_count     (err_count),
        .tmo_count     (tmo_count)
    );

endmodule

//--- logic/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    // write address channel payload
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_ar_t;

    // read data with its response in the low bits
    typedef struct packed {
        logic [data_w-1:0] data;
        axi_resp_e         resp;
    } axi_r_t;

endpackage

//--- logic/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_req,
    input  host_pkg::host_req_t        req,
    input  logic [host_pkg::tmo_w-1:0] timeout_limit,
    output axi_lite_pkg::axi_ar_t      ar,
    output logic                       arvalid,
    input  logic                       arready,
    input  axi_lite_pkg::axi_r_t       r,
    input  logic                       rvalid,
    output logic                       rready,
    output logic                       rd_done,
    output host_pkg::host_rsp_t        rd_rsp,
    output logic                       busy
);
    import host_pkg::*;

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_data
    } rd_state_e;

    rd_state_e        state;
    rd_state_e        state_next;
    logic [tmo_w-1:0] wait_cnt;
    logic [tmo_w-1:0] lim_q;
    logic             accept;
    logic             r_hs;
    logic             tmo_hit;

    assign busy    = (state != rd_idle) || rd_done;
    assign accept  = rd_req && !busy;
    assign arvalid = (state == rd_addr);
    assign rready  = (state == rd_data) && rvalid;
    assign r_hs    = rready;

    // counter is zero one cycle after acceptance, so limit-1 lands done at T+limit+1
    assign tmo_hit = (state != rd_idle) && !r_hs && (wait_cnt == lim_q - 1'b1);

    always_comb begin
        state_next = state;
        case (state)
            rd_idle: if (accept) state_next = rd_addr;
            rd_addr: if (tmo_hit) state_next = rd_idle;
                     else if (arready) state_next = rd_data;
            rd_data: if (r_hs || tmo_hit) state_next = rd_idle;
            default: state_next = rd_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rd_idle;
            rd_done  <= 1'b0;
            wait_cnt <= '0;
        end else begin
            state   <= state_next;
            rd_done <= r_hs || tmo_hit;
            if (accept) begin
                wait_cnt <= '0;
            end else if (state != rd_idle) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // limit sampled per request
    always_ff @(posedge clk) begin
        if (accept) begin
            ar.addr <= req.addr;
            lim_q   <= timeout_limit;
        end
        if (r_hs) begin
            rd_rsp.status <= to_status(r.resp);
            rd_rsp.data   <= r.data;
        end else if (tmo_hit) begin
            rd_rsp.status <= st_timeout;
            rd_rsp.data   <= '0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready && !tmo_hit |=> arvalid && $stable(ar));

endmodule

//--- logic/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_req,
    input  host_pkg::host_req_t   req,
    output axi_lite_pkg::axi_aw_t aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_lite_pkg::axi_w_t  w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_lite_pkg::axi_b_t  b,
    input  logic                  bvalid,
    output logic                  bready,
    output logic                  wr_done,
    output host_pkg::host_rsp_t   wr_rsp,
    output logic                  busy
);
    import host_pkg::*;

    typedef enum logic [1:0] {
        ch_wait,
        ch_send,
        ch_sent
    } ch_state_e;

    ch_state_e aw_state;
    ch_state_e w_state;
    logic      accept;
    logic      resp_wait;
    logic      b_hs;

    // one step of a channel machine, shared by aw and w
    function automatic ch_state_e ch_step(ch_state_e s, logic go, logic rdy, logic fin);
        case (s)
            ch_wait: return go ? ch_send : ch_wait;
            ch_send: return rdy ? ch_sent : ch_send;
            ch_sent: return fin ? ch_wait : ch_sent;
            default: return ch_wait;
        endcase
    endfunction

    assign busy      = (aw_state != ch_wait) || (w_state != ch_wait) || wr_done;
    assign accept    = wr_req && !busy;
    assign resp_wait = (aw_state == ch_sent) && (w_state == ch_sent);
    assign bready    = resp_wait && bvalid;
    assign b_hs      = bready;

    assign awvalid = (aw_state == ch_send);
    assign wvalid  = (w_state == ch_send);

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_state <= ch_wait;
            w_state  <= ch_wait;
            wr_done  <= 1'b0;
        end else begin
            aw_state <= ch_step(aw_state, accept, awready, b_hs);
            w_state  <= ch_step(w_state, accept, wready, b_hs);
            wr_done  <= b_hs;
        end
    end

    // payload held from acceptance until the handshakes
    always_ff @(posedge clk) begin
        if (accept) begin
            aw.addr <= req.addr;
            w.data  <= req.data;
        end
        if (b_hs) begin
            wr_rsp.status <= to_status(b.resp);
            wr_rsp.data   <= '0;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw));

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w));

    // an idle engine has nothing to complete
    no_done_idle: assert property (@(posedge clk) disable iff (rst)
        !busy |=> !wr_done);

endmodule

//--- logic/bridge_cfg_regs.sv
`timescale 1ns/1ps

module bridge_cfg_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_we,
    input  logic [host_pkg::tmo_w-1:0] cfg_limit,
    input  logic                       wr_done,
    input  host_pkg::host_rsp_t        wr_rsp,
    input  logic                       rd_done,
    input  host_pkg::host_rsp_t        rd_rsp,
    output logic [host_pkg::tmo_w-1:0] timeout_limit,
    output logic [host_pkg::tmo_w-1:0] err_count,
    output logic [host_pkg::tmo_w-1:0] tmo_count
);
    import host_pkg::*;

    logic           wr_err;
    logic           rd_err;
    logic           rd_tmo;
    logic [1:0]     err_inc;
    logic [tmo_w:0] err_sum;

    assign wr_err = wr_done && (wr_rsp.status == st_slverr || wr_rsp.status == st_decerr);
    assign rd_err = rd_done && (rd_rsp.status == st_slverr || rd_rsp.status == st_decerr);
    assign rd_tmo = rd_done && (rd_rsp.status == st_timeout);

    // both engines may report an error in the same cycle
    assign err_inc = {1'b0, wr_err} + {1'b0, rd_err};
    assign err_sum = {1'b0, err_count} + (tmo_w + 1)'(err_inc);

    always_ff @(posedge clk) begin
        if (rst) begin
            timeout_limit <= tmo_w'(tmo_default);
            err_count     <= '0;
            tmo_count     <= '0;
        end else begin
            if (cfg_we && cfg_limit != '0) begin
                timeout_limit <= cfg_limit;
            end
            // saturate at all ones
            if (err_sum[tmo_w]) begin
                err_count <= '1;
            end else begin
                err_count <= err_sum[tmo_w-1:0];
            end
            if (rd_tmo && tmo_count != '1) begin
                tmo_count <= tmo_count + 1'b1;
            end
        end
    end

    limit_nonzero: assert property (@(posedge clk) disable iff (rst)
        timeout_limit != '0);

endmodule

//--- logic/host_pkg.sv
package host_pkg;

    localparam int tmo_w       = 8;
    localparam int tmo_default = 100;

    typedef struct packed {
        logic [axi_lite_pkg::addr_w-1:0] addr;
        logic [axi_lite_pkg::data_w-1:0] data;
    } host_req_t;

    typedef enum logic [1:0] {
        st_okay,
        st_slverr,
        st_decerr,
        st_timeout
    } xfer_status_e;

    typedef struct packed {
        xfer_status_e                    status;
        logic [axi_lite_pkg::data_w-1:0] data;
    } host_rsp_t;

    // exokay has no meaning without exclusive access, so it counts as okay
    function automatic xfer_status_e to_status(axi_lite_pkg::axi_resp_e resp);
        case (resp)
            axi_lite_pkg::slverr: return st_slverr;
            axi_lite_pkg::decerr: return st_decerr;
            default:              return st_okay;
        endcase
    endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_axi_lite_master -f axi_lite_master_top.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation did not pass"; exit 1; }
